// File: hdl/cpu_params_pkg.sv
package cpu_params_pkg;

    //////////////////////////////////////////////////
    // Machine widths
    //////////////////////////////////////////////////

    // Integer datapath width
    localparam int XLEN = 32;

    // Half word, used by the split multiplier
    localparam int XLEN_HALF = XLEN / 2;

    // Enough tags for 64 micro-ops in flight
    localparam int TAG_WIDTH = 6;

    // Operand and result word
    typedef logic [XLEN-1:0] xlen_data_t;

    // Half of an operand word
    typedef logic [XLEN_HALF-1:0] xlen_half_t;

    // Micro-op identifier, unique while in flight
    typedef logic [TAG_WIDTH-1:0] rob_tag_t;

endpackage

// File: hdl/uop_types_pkg.sv
package uop_types_pkg;

    // Target reservation station
    typedef enum logic {
        RS_INT  = 1'b0,
        RS_INTM = 1'b1
    } rs_type_e;

    // Operation encodings
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } alu_op_e;

    // One renamed micro-op, operand values already resolved
    typedef struct packed {
        logic                       valid;
        rs_type_e                   rs_type;
        alu_op_e                    op;
        cpu_params_pkg::rob_tag_t   tag;
        cpu_params_pkg::xlen_data_t src_a;
        cpu_params_pkg::xlen_data_t src_b;
    } uop_t;

    // One completed result
    typedef struct packed {
        logic                       valid;
        cpu_params_pkg::rob_tag_t   tag;
        cpu_params_pkg::xlen_data_t data;
    } wb_result_t;

endpackage

// File: hdl/ds_stage.sv
module ds_stage #(
    parameter int ID_WIDTH = 2
) (
    input  logic                prv_valid,
    output logic                prv_ready,
    input  uop_types_pkg::uop_t uops [ID_WIDTH],
    output logic [ID_WIDTH-1:0] int_wr_en,
    output logic [ID_WIDTH-1:0] intm_wr_en,
    output uop_types_pkg::uop_t int_wr_uops [ID_WIDTH],
    output uop_types_pkg::uop_t intm_wr_uops [ID_WIDTH],
    input  logic                int_ready,
    input  logic                intm_ready
);

    import uop_types_pkg::*;

    logic [ID_WIDTH-1:0] lane_to_int;
    logic [ID_WIDTH-1:0] lane_to_intm;
    logic [ID_WIDTH-1:0] lane_ready;
    logic                fire;

    // Station decode, only valid lanes claim a station
    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            lane_to_int[i]  = 1'b0;
            lane_to_intm[i] = 1'b0;
            if (uops[i].valid) begin
                case (uops[i].rs_type)
                    RS_INT:  lane_to_int[i]  = 1'b1;
                    RS_INTM: lane_to_intm[i] = 1'b1;
                    default: lane_to_int[i]  = 1'b0;
                endcase
            end
        end
    end

    // A lane blocks only if its target station lacks room
    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            lane_ready[i] = !(lane_to_int[i] && !int_ready) &&
                            !(lane_to_intm[i] && !intm_ready);
        end
    end

    // Independent of prv_valid
    assign prv_ready = &lane_ready;
    assign fire      = prv_valid && prv_ready;

    assign int_wr_en  = lane_to_int & {ID_WIDTH{fire}};
    assign intm_wr_en = lane_to_intm & {ID_WIDTH{fire}};

    // Both stations see the full bundle, wr_en picks the lanes
    for (genvar i = 0; i < ID_WIDTH; i++) begin : g_lane
        assign int_wr_uops[i]  = uops[i];
        assign intm_wr_uops[i] = uops[i];
    end

endmodule

// File: hdl/rs_queue.sv
module rs_queue #(
    parameter int ID_WIDTH = 2,
    parameter int DEPTH    = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [ID_WIDTH-1:0] wr_en,
    input  uop_types_pkg::uop_t wr_uops [ID_WIDTH],
    output logic                ready,
    output logic                issue_valid,
    output uop_types_pkg::uop_t issue_uop,
    input  logic                issue_ready
);

    import uop_types_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    localparam cnt_t DEPTH_V = cnt_t'(DEPTH);
    localparam cnt_t LANES_V = cnt_t'(ID_WIDTH);

    uop_t mem [DEPTH];
    ptr_t head;
    ptr_t tail;
    cnt_t count;
    cnt_t free_cnt;
    cnt_t wr_cnt;
    ptr_t wr_idx [ID_WIDTH];
    logic pop;

    // Pointer advance with wrap for any depth
    function automatic ptr_t wrap_add(input ptr_t base, input cnt_t inc);
        cnt_t sum;
        sum = {1'b0, base} + inc;
        if (sum >= DEPTH_V) begin
            sum = sum - DEPTH_V;
        end
        return sum[PTR_W-1:0];
    endfunction

    //////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////

    // Enabled lanes land in consecutive slots, lane order kept
    always_comb begin
        wr_cnt = '0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            wr_idx[i] = wrap_add(tail, wr_cnt);
            wr_cnt    = wr_cnt + cnt_t'(wr_en[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            if (wr_en[i]) begin
                mem[wr_idx[i]] <= wr_uops[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Occupancy and issue
    //////////////////////////////////////////////////

    assign pop = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= wrap_add(head, cnt_t'(pop));
            tail  <= wrap_add(tail, wr_cnt);
            count <= count + wr_cnt - cnt_t'(pop);
        end
    end

    // Room for a whole bundle
    assign free_cnt = DEPTH_V - count;
    assign ready    = free_cnt >= LANES_V;

    // Oldest entry goes first
    assign issue_valid = count != '0;
    assign issue_uop   = mem[head];

endmodule

// File: hdl/int_alu_unit.sv
module int_alu_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  uop_types_pkg::uop_t       issue_uop,
    input  logic                      issue_ready,
    output uop_types_pkg::wb_result_t result
);

    import cpu_params_pkg::*;
    import uop_types_pkg::*;

    xlen_data_t alu_data;
    logic       fire;
    logic       res_valid;
    rob_tag_t   res_tag;
    xlen_data_t res_data;

    always_comb begin
        case (issue_uop.op)
            OP_ADD:  alu_data = issue_uop.src_a + issue_uop.src_b;
            OP_SUB:  alu_data = issue_uop.src_a - issue_uop.src_b;
            OP_AND:  alu_data = issue_uop.src_a & issue_uop.src_b;
            OP_XOR:  alu_data = issue_uop.src_a ^ issue_uop.src_b;
            default: alu_data = '0;
        endcase
    end

    assign fire = issue_valid && issue_ready;

    // Result stays put while writeback is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (issue_ready) begin
            res_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_tag  <= issue_uop.tag;
            res_data <= alu_data;
        end
    end

    assign result = '{valid: res_valid, tag: res_tag, data: res_data};

endmodule

// File: hdl/intm_mul_unit.sv
module intm_mul_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  uop_types_pkg::uop_t       issue_uop,
    output uop_types_pkg::wb_result_t result
);

    import cpu_params_pkg::*;
    import uop_types_pkg::*;

    // Stage 1 holds the operands
    logic       s1_valid;
    rob_tag_t   s1_tag;
    xlen_data_t s1_a;
    xlen_data_t s1_b;

    // Stage 2 holds the partial products
    logic       s2_valid;
    rob_tag_t   s2_tag;
    xlen_data_t s2_low;
    xlen_half_t s2_cross;

    // Stage 3 holds the low word of the product
    logic       s3_valid;
    rob_tag_t   s3_tag;
    xlen_data_t s3_prod;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag <= issue_uop.tag;
        s1_a   <= issue_uop.src_a;
        s1_b   <= issue_uop.src_b;
        s2_tag <= s1_tag;
        s2_low <= xlen_data_t'(s1_a[XLEN_HALF-1:0]) * xlen_data_t'(s1_b[XLEN_HALF-1:0]);
        // Only the low half of the cross terms reaches the low word
        s2_cross <= s1_a[XLEN_HALF-1:0] * s1_b[XLEN-1:XLEN_HALF] +
                    s1_a[XLEN-1:XLEN_HALF] * s1_b[XLEN_HALF-1:0];
        s3_tag  <= s2_tag;
        s3_prod <= s2_low + {s2_cross, {XLEN_HALF{1'b0}}};
    end

    assign result = '{valid: s3_valid, tag: s3_tag, data: s3_prod};

endmodule

// File: hdl/wb_arbiter.sv
module wb_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  uop_types_pkg::wb_result_t int_result,
    input  uop_types_pkg::wb_result_t intm_result,
    output logic                      int_ready,
    output uop_types_pkg::wb_result_t wb_result
);

    import uop_types_pkg::*;

    wb_result_t hold_q;
    wb_result_t out_sel;
    wb_result_t out_q;
    logic       hold_load;
    logic       hold_clear;

    // INT side stalls while a result waits in the hold buffer
    assign int_ready = !hold_q.valid;

    //////////////////////////////////////////////////
    // Selection, INTM first
    //////////////////////////////////////////////////

    always_comb begin
        out_sel    = '0;
        hold_load  = 1'b0;
        hold_clear = 1'b0;
        if (intm_result.valid) begin
            out_sel   = intm_result;
            hold_load = int_result.valid && int_ready;
        end else if (hold_q.valid) begin
            out_sel    = hold_q;
            hold_clear = 1'b1;
        end else if (int_result.valid) begin
            out_sel = int_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_q.valid <= 1'b0;
            out_q.valid  <= 1'b0;
        end else begin
            out_q.valid <= out_sel.valid;
            if (hold_load) begin
                hold_q.valid <= 1'b1;
            end else if (hold_clear) begin
                hold_q.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        out_q.tag  <= out_sel.tag;
        out_q.data <= out_sel.data;
        if (hold_load) begin
            hold_q.tag  <= int_result.tag;
            hold_q.data <= int_result.data;
        end
    end

    assign wb_result = out_q;

endmodule

// File: hdl/dispatch_core_top.sv
module dispatch_core_top #(
    parameter int ID_WIDTH      = 2,
    parameter int INT_RS_DEPTH  = 8,
    parameter int INTM_RS_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      prv_valid,
    input  uop_types_pkg::uop_t       uops [ID_WIDTH],
    output logic                      prv_ready,
    output uop_types_pkg::wb_result_t wb_result
);

    import uop_types_pkg::*;

    logic [ID_WIDTH-1:0] int_wr_en;
    logic [ID_WIDTH-1:0] intm_wr_en;
    uop_t                int_wr_uops [ID_WIDTH];
    uop_t                intm_wr_uops [ID_WIDTH];
    logic                int_rs_ready;
    logic                intm_rs_ready;
    logic                int_issue_valid;
    uop_t                int_issue_uop;
    logic                intm_issue_valid;
    uop_t                intm_issue_uop;
    logic                int_ready;
    wb_result_t          int_result;
    wb_result_t          intm_result;

    //////////////////////////////////////////////////
    // Dispatch
    //////////////////////////////////////////////////

    ds_stage #(.ID_WIDTH(ID_WIDTH)) i_ds_stage (
        .prv_valid(prv_valid),       .prv_ready(prv_ready),         .uops(uops),
        .int_wr_en(int_wr_en),       .intm_wr_en(intm_wr_en),
        .int_wr_uops(int_wr_uops),   .intm_wr_uops(intm_wr_uops),
        .int_ready(int_rs_ready),    .intm_ready(intm_rs_ready)
    );

    //////////////////////////////////////////////////
    // Stations and units
    //////////////////////////////////////////////////

    rs_queue #(.ID_WIDTH(ID_WIDTH), .DEPTH(INT_RS_DEPTH)) i_int_rs (
        .clk(clk), .rst(rst), .wr_en(int_wr_en), .wr_uops(int_wr_uops),
        .ready(int_rs_ready), .issue_valid(int_issue_valid),
        .issue_uop(int_issue_uop), .issue_ready(int_ready)
    );

    // Multiplier is fully pipelined and never stalls
    rs_queue #(.ID_WIDTH(ID_WIDTH), .DEPTH(INTM_RS_DEPTH)) i_intm_rs (
        .clk(clk), .rst(rst), .wr_en(intm_wr_en), .wr_uops(intm_wr_uops),
        .ready(intm_rs_ready), .issue_valid(intm_issue_valid),
        .issue_uop(intm_issue_uop), .issue_ready(1'b1)
    );

    int_alu_unit i_int_alu (
        .clk(clk), .rst(rst), .issue_valid(int_issue_valid), .issue_uop(int_issue_uop),
        .issue_ready(int_ready), .result(int_result)
    );

    intm_mul_unit i_intm_mul (
        .clk(clk), .rst(rst), .issue_valid(intm_issue_valid), .issue_uop(intm_issue_uop),
        .result(intm_result)
    );

    wb_arbiter i_wb_arbiter (
        .clk(clk), .rst(rst), .int_result(int_result), .intm_result(intm_result),
        .int_ready(int_ready), .wb_result(wb_result)
    );

endmodule

// File: dv/dispatch_core_props.sv
module dispatch_core_props #(
    parameter int ID_WIDTH = 2
) (
    input logic                       clk,
    input logic                       rst,
    input logic                       prv_valid,
    input logic                       prv_ready,
    input uop_types_pkg::uop_t        uops [ID_WIDTH],
    input uop_types_pkg::wb_result_t  wb_result
);

    import cpu_params_pkg::*;
    import uop_types_pkg::*;

    localparam int NUM_TAGS = 2 ** TAG_WIDTH;

    int         fail_count = 0;
    logic       rst_q;
    logic       pending [NUM_TAGS];
    logic       is_mul [NUM_TAGS];
    xlen_data_t exp_data [NUM_TAGS];
    rob_tag_t   int_order [NUM_TAGS];
    rob_tag_t   mul_order [NUM_TAGS];
    rob_tag_t   int_head;
    rob_tag_t   int_tail;
    rob_tag_t   mul_head;
    rob_tag_t   mul_tail;
    logic       res_pending;
    logic       res_is_mul;
    xlen_data_t res_exp;
    rob_tag_t   res_head;

    // Reference result straight from the operation definitions
    function automatic xlen_data_t expected_data(input uop_t u);
        logic [2*XLEN-1:0] product;
        product = {{XLEN{1'b0}}, u.src_a} * {{XLEN{1'b0}}, u.src_b};
        case (u.op)
            OP_ADD:  return u.src_a + u.src_b;
            OP_SUB:  return u.src_a - u.src_b;
            OP_AND:  return u.src_a & u.src_b;
            OP_XOR:  return u.src_a ^ u.src_b;
            OP_MUL:  return product[XLEN-1:0];
            default: return '0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Expected-result table and per-station order
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        rst_q <= rst;
    end

    always @(posedge clk) begin : track_dispatch
        rob_tag_t int_slot;
        rob_tag_t mul_slot;
        int_slot = int_tail;
        mul_slot = mul_tail;
        if (rst) begin
            for (int t = 0; t < NUM_TAGS; t++) begin
                pending[t] <= 1'b0;
            end
            int_head <= '0;
            int_tail <= '0;
            mul_head <= '0;
            mul_tail <= '0;
        end else begin
            // Retire first, a freed tag may be dispatched again on this edge
            if (wb_result.valid) begin
                pending[wb_result.tag] <= 1'b0;
                if (is_mul[wb_result.tag]) begin
                    mul_head <= mul_head + 1'b1;
                end else begin
                    int_head <= int_head + 1'b1;
                end
            end
            if (prv_valid && prv_ready) begin
                for (int i = 0; i < ID_WIDTH; i++) begin
                    if (uops[i].valid) begin
                        pending[uops[i].tag]  <= 1'b1;
                        is_mul[uops[i].tag]   <= uops[i].rs_type == RS_INTM;
                        exp_data[uops[i].tag] <= expected_data(uops[i]);
                        if (uops[i].rs_type == RS_INTM) begin
                            mul_order[mul_slot] <= uops[i].tag;
                            mul_slot = mul_slot + 1'b1;
                        end else begin
                            int_order[int_slot] <= uops[i].tag;
                            int_slot = int_slot + 1'b1;
                        end
                    end
                end
                int_tail <= int_slot;
                mul_tail <= mul_slot;
            end
        end
    end

    assign res_pending = pending[wb_result.tag];
    assign res_is_mul  = is_mul[wb_result.tag];
    assign res_exp     = exp_data[wb_result.tag];
    assign res_head    = res_is_mul ? mul_order[mul_head] : int_order[int_head];

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_reset_idle: assert property (@(posedge clk) rst_q |-> !wb_result.valid && prv_ready)
        else begin
            $error("FAILED wb_result.valid=%h prv_ready=%h around reset",
                   $sampled(wb_result.valid), $sampled(prv_ready));
            fail_count++;
        end

    a_tag_pending: assert property (@(posedge clk) disable iff (rst)
        wb_result.valid |-> res_pending)
        else begin
            $error("FAILED wb_result.tag=%h has no pending micro-op", $sampled(wb_result.tag));
            fail_count++;
        end

    a_int_data: assert property (@(posedge clk) disable iff (rst)
        wb_result.valid && res_pending && !res_is_mul |-> wb_result.data == res_exp)
        else begin
            $error("FAILED wb_result.data=%h expected %h for INT tag %h",
                   $sampled(wb_result.data), $sampled(res_exp), $sampled(wb_result.tag));
            fail_count++;
        end

    a_mul_data: assert property (@(posedge clk) disable iff (rst)
        wb_result.valid && res_pending && res_is_mul |-> wb_result.data == res_exp)
        else begin
            $error("FAILED wb_result.data=%h expected %h for MUL tag %h",
                   $sampled(wb_result.data), $sampled(res_exp), $sampled(wb_result.tag));
            fail_count++;
        end

    // Each station returns its results in dispatch order
    a_stream_order: assert property (@(posedge clk) disable iff (rst)
        wb_result.valid && res_pending |-> wb_result.tag == res_head)
        else begin
            $error("FAILED wb_result.tag=%h expected %h",
                   $sampled(wb_result.tag), $sampled(res_head));
            fail_count++;
        end

endmodule

bind dispatch_core_top dispatch_core_props #(.ID_WIDTH(ID_WIDTH)) i_props (
    .clk(clk), .rst(rst), .prv_valid(prv_valid), .prv_ready(prv_ready),
    .uops(uops), .wb_result(wb_result)
);

// File: dv/tb_dispatch_core.sv
module tb_dispatch_core;

    import cpu_params_pkg::*;
    import uop_types_pkg::*;

    localparam int ID_WIDTH       = 2;
    localparam int CLK_PERIOD     = 8;
    localparam int NUM_TAGS       = 2 ** TAG_WIDTH;
    localparam int RANDOM_BUNDLES = 300;
    localparam int BURST_BUNDLES  = 12;
    localparam int TOTAL_BUNDLES  = RANDOM_BUNDLES + 2 * BURST_BUNDLES;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_BUNDLES;

    typedef enum int {
        MIX_RANDOM,
        MIX_MUL_ONLY,
        MIX_ADD_ONLY
    } mix_e;

    logic       clk;
    logic       rst;
    logic       prv_valid;
    logic       prv_ready;
    uop_t       uops [ID_WIDTH];
    wb_result_t wb_result;
    rob_tag_t   free_tags [$];
    int         in_flight;

    dispatch_core_top #(.ID_WIDTH(ID_WIDTH)) i_dut (
        .clk(clk), .rst(rst), .prv_valid(prv_valid), .uops(uops),
        .prv_ready(prv_ready), .wb_result(wb_result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // Step to the next falling edge and return a finished tag to the pool
    task automatic next_cycle();
        @(negedge clk);
        if (wb_result.valid) begin
            free_tags.push_back(wb_result.tag);
            in_flight--;
        end
    endtask

    function automatic uop_t random_uop(input mix_e mix, input rob_tag_t tag);
        uop_t u;
        u       = '0;
        u.valid = 1'b1;
        u.tag   = tag;
        u.src_a = $urandom();
        u.src_b = $urandom();
        case (mix)
            MIX_MUL_ONLY: u.rs_type = RS_INTM;
            MIX_ADD_ONLY: u.rs_type = RS_INT;
            default:      u.rs_type = rs_type_e'($urandom_range(1, 0));
        endcase
        if (u.rs_type == RS_INTM) begin
            u.op = OP_MUL;
        end else if (mix == MIX_ADD_ONLY) begin
            u.op = OP_ADD;
        end else begin
            u.op = alu_op_e'($urandom_range(3, 0));
        end
        return u;
    endfunction

    // Drive one bundle and hold it until dispatch takes it
    task automatic send_bundle(input mix_e mix);
        logic take;
        for (int i = 0; i < ID_WIDTH; i++) begin
            take = free_tags.size() != 0 && (mix != MIX_RANDOM || $urandom_range(3, 0) != 0);
            if (take) begin
                uops[i] = random_uop(mix, free_tags.pop_front());
                in_flight++;
            end else begin
                // Invalid lanes carry junk and must not block
                uops[i]       = random_uop(mix, rob_tag_t'($urandom()));
                uops[i].valid = 1'b0;
            end
        end
        prv_valid = 1'b1;
        #1;
        while (!prv_ready) begin
            next_cycle();
            #1;
        end
        next_cycle();
        prv_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(81640));
        clk       = 1'b0;
        rst       = 1'b1;
        prv_valid = 1'b0;
        in_flight = 0;
        // Valid lanes on both stations make prv_ready depend on their reset state
        for (int i = 0; i < ID_WIDTH; i++) begin
            if (i % 2 == 0) begin
                uops[i] = random_uop(MIX_ADD_ONLY, rob_tag_t'(i));
            end else begin
                uops[i] = random_uop(MIX_MUL_ONLY, rob_tag_t'(i));
            end
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            free_tags.push_back(rob_tag_t'(t));
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (int b = 0; b < RANDOM_BUNDLES; b++) begin
            send_bundle(MIX_RANDOM);
            if ($urandom_range(3, 0) == 0) begin
                repeat ($urandom_range(3, 1)) next_cycle();
            end
        end

        // Back-to-back bursts fill each station
        repeat (BURST_BUNDLES) send_bundle(MIX_MUL_ONLY);
        repeat (BURST_BUNDLES) send_bundle(MIX_ADD_ONLY);

        while (in_flight != 0) begin
            next_cycle();
        end
        // Last result is checked on the following edge
        repeat (2) next_cycle();

        if (i_dut.i_props.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_with_failure("Assertion failures were reported during the run");
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_props.fail_count != 0) begin
            stop_with_failure("An assertion failed, see the error line above");
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        stop_with_failure($sformatf("Watchdog expired with %0d results still missing",
                                    in_flight));
    end

endmodule

// File: vlog.f
hdl/cpu_params_pkg.sv
hdl/uop_types_pkg.sv
hdl/ds_stage.sv
hdl/rs_queue.sv
hdl/int_alu_unit.sv
hdl/intm_mul_unit.sv
hdl/wb_arbiter.sv
hdl/dispatch_core_top.sv
dv/dispatch_core_props.sv
dv/tb_dispatch_core.sv

// File: Bender.yml
package:
  name: dispatch_core

sources:
  - files:
      - hdl/cpu_params_pkg.sv
      - hdl/uop_types_pkg.sv
      - hdl/ds_stage.sv
      - hdl/rs_queue.sv
      - hdl/int_alu_unit.sv
      - hdl/intm_mul_unit.sv
      - hdl/wb_arbiter.sv
      - hdl/dispatch_core_top.sv
  - target: test
    files:
      - dv/dispatch_core_props.sv
      - dv/tb_dispatch_core.sv
